// File: Makefile
TOP = tb_usb_trigger

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "^Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/pw_trig_pkg.sv
package pw_trig_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // sizes
   ////////////////////////////////////////////////////////////////////////////

   localparam int PATTERN_BYTES = 4;    // bytes in the match window
   localparam int DELAY_WIDTH   = 20;   // trigger delay, in fe_clk cycles
   localparam int PULSE_WIDTH   = 17;   // trigger pulse width, in fe_clk cycles

   ////////////////////////////////////////////////////////////////////////////
   // types
   ////////////////////////////////////////////////////////////////////////////

   // byte 0 is the oldest byte of the window
   typedef logic [PATTERN_BYTES-1:0][7:0] pattern_t;

   // timer count, wide enough for the delay
   // the pulse width is zero extended into it
   typedef logic [DELAY_WIDTH-1:0] timer_t;

   // trigger sequencer states
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,   // waiting for arm
      ST_ARMED = 2'd1,   // waiting for a pattern match
      ST_DELAY = 2'd2,   // counting the trigger delay
      ST_PULSE = 2'd3    // driving the trigger output
   } trig_state_e;

endpackage

// File: hw/trigger_sequencer.sv
`timescale 1ns/100ps

module trigger_sequencer
   import pw_trig_pkg::*;
(
   input  logic                   fe_clk,
   input  logic                   rst_n_i,
   input  logic                   arm_i,
   input  logic                   match_i,
   input  logic [DELAY_WIDTH-1:0] delay_i,
   input  logic [PULSE_WIDTH-1:0] width_i,
   input  logic                   done_i,
   output logic                   load_o,
   output timer_t                 load_value_o,
   output logic                   trig_o,
   output logic                   armed_o
);

   trig_state_e state_q;
   trig_state_e state_n;
   logic        delay_load;     // load issued as the match is taken
   logic        pulse_load_q;   // first cycle of PULSE, width being loaded

   ////////////////////////////////////////////////////////////////////////////
   // state machine
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_n = state_q;
      unique case (state_q)
         ST_IDLE:  if (arm_i)   state_n = ST_ARMED;
         ST_ARMED: if (match_i) state_n = ST_DELAY;
         ST_DELAY: if (done_i)  state_n = ST_PULSE;
         ST_PULSE: if (done_i)  state_n = ST_IDLE;    // one trigger per arm
         default:               state_n = ST_IDLE;
      endcase
   end

   always_ff @(posedge fe_clk) begin
      if (!rst_n_i) begin
         state_q      <= ST_IDLE;
         pulse_load_q <= 1'b0;
      end else begin
         state_q      <= state_n;
         pulse_load_q <= (state_q == ST_DELAY) && done_i;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // timer control
   ////////////////////////////////////////////////////////////////////////////

   // delay goes in on the match edge, so the count starts right away
   assign delay_load = (state_q == ST_ARMED) && match_i;

   // pulse load comes from a register and cannot loop back through done_i
   assign load_o = delay_load || pulse_load_q;

   always_comb begin
      if (state_q == ST_ARMED) begin
         load_value_o = delay_i;
      end else begin
         load_value_o = timer_t'(width_i) - 1'b1;   // width_i >= 1
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // outputs
   ////////////////////////////////////////////////////////////////////////////

   // pulse starts once the width is in the timer
   assign trig_o  = (state_q == ST_PULSE) && !pulse_load_q;
   assign armed_o = (state_q == ST_ARMED);

endmodule

// File: hw/trigger_timer.sv
`timescale 1ns/100ps

module trigger_timer
   import pw_trig_pkg::*;
(
   input  logic   fe_clk,
   input  logic   rst_n_i,
   input  logic   load_i,
   input  timer_t load_value_i,
   output logic   done_o
);

   timer_t count;

   // loadable down counter, holds at zero
   always_ff @(posedge fe_clk) begin
      if (!rst_n_i) begin
         count <= '0;
      end else if (load_i) begin
         count <= load_value_i;
      end else if (count != '0) begin
         count <= count - 1'b1;
      end
   end

   // a pending load hides the stale zero of the previous phase
   assign done_o = (count == '0) && !load_i;

endmodule

// File: hw/usb_pattern_matcher.sv
`timescale 1ns/100ps

module usb_pattern_matcher
   import pw_trig_pkg::*;
(
   input  logic       fe_clk,
   input  logic       rst_n_i,
   input  logic [7:0] fe_data_i,
   input  logic       fe_rxvalid_i,
   input  logic       fe_rxactive_i,
   input  pattern_t   pattern_i,
   input  pattern_t   mask_i,
   output logic       match_o
);

   pattern_t                       window;       // last bytes of current packet
   pattern_t                       window_next;  // window incl. the byte on the bus
   logic [$clog2(PATTERN_BYTES):0] byte_cnt;     // saturates at PATTERN_BYTES
   logic                           accept;
   logic                           window_full;
   logic                           hit;

   ////////////////////////////////////////////////////////////////////////////
   // byte window
   ////////////////////////////////////////////////////////////////////////////

   assign accept = fe_rxactive_i && fe_rxvalid_i;

   // newest byte enters at the top, oldest drops out of byte 0
   assign window_next = {fe_data_i, window[PATTERN_BYTES-1:1]};

   // the incoming byte completes a full window
   assign window_full = (byte_cnt >= PATTERN_BYTES - 1);

   // compare only the bits selected by the mask
   assign hit = ((window_next ^ pattern_i) & mask_i) == '0;

   always_ff @(posedge fe_clk) begin
      if (!rst_n_i) begin
         window   <= '0;
         byte_cnt <= '0;
      end else if (!fe_rxactive_i) begin
         // end of packet, start the next one empty
         window   <= '0;
         byte_cnt <= '0;
      end else if (fe_rxvalid_i) begin
         window <= window_next;
         if (byte_cnt != PATTERN_BYTES) begin
            byte_cnt <= byte_cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // match strobe
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge fe_clk) begin
      if (!rst_n_i) begin
         match_o <= 1'b0;
      end else begin
         match_o <= accept && window_full && hit;   // one cycle per accepted byte
      end
   end

endmodule

// File: hw/usb_trigger_top.sv
`timescale 1ns/100ps

module usb_trigger_top
   import pw_trig_pkg::*;
(
   input  logic                   fe_clk,
   input  logic                   rst_n_i,
   input  logic [7:0]             fe_data_i,
   input  logic                   fe_rxvalid_i,
   input  logic                   fe_rxactive_i,
   input  logic                   arm_i,
   input  pattern_t               pattern_i,
   input  pattern_t               mask_i,
   input  logic [DELAY_WIDTH-1:0] delay_i,
   input  logic [PULSE_WIDTH-1:0] width_i,
   output logic                   trig_o,    // drives both the cw and mcx trigger
   output logic                   armed_o
);

   logic   match;
   logic   load;
   timer_t load_value;
   logic   done;

   usb_pattern_matcher i_matcher (
      .fe_clk        (fe_clk),
      .rst_n_i       (rst_n_i),
      .fe_data_i     (fe_data_i),
      .fe_rxvalid_i  (fe_rxvalid_i),
      .fe_rxactive_i (fe_rxactive_i),
      .pattern_i     (pattern_i),
      .mask_i        (mask_i),
      .match_o       (match)
   );

   trigger_sequencer i_sequencer (
      .fe_clk        (fe_clk),
      .rst_n_i       (rst_n_i),
      .arm_i         (arm_i),
      .match_i       (match),
      .delay_i       (delay_i),
      .width_i       (width_i),
      .done_i        (done),
      .load_o        (load),
      .load_value_o  (load_value),
      .trig_o        (trig_o),
      .armed_o       (armed_o)
   );

   // one counter times delay and pulse
   trigger_timer i_timer (
      .fe_clk        (fe_clk),
      .rst_n_i       (rst_n_i),
      .load_i        (load),
      .load_value_i  (load_value),
      .done_o        (done)
   );

endmodule

// File: tb.f
hw/pw_trig_pkg.sv
hw/usb_pattern_matcher.sv
hw/trigger_timer.sv
hw/trigger_sequencer.sv
hw/usb_trigger_top.sv
verification/usb_trigger_sva.sv
verification/tb_usb_trigger.sv

// File: verification/tb_usb_trigger.sv
`timescale 1ns/100ps

module tb_usb_trigger
   import pw_trig_pkg::*;
();

   localparam int SLACK = 24;   // extra cycles allowed around each expected event

   typedef struct {
      logic [63:0]            data;         // byte 0 goes out first
      int                     len;
      bit                     gap;          // idle cycle between bytes
      int                     split;        // rxactive drop before this byte, 0 for none
      bit                     arm;
      bit                     keep;         // no reset before the row
      bit                     arm_late;     // extra arm strobe during the delay
      bit                     rand_fill;    // masked-out window bytes get random data
      pattern_t               pattern;
      pattern_t               mask;
      logic [DELAY_WIDTH-1:0] delay;
      logic [PULSE_WIDTH-1:0] width;
      bit                     expect_trig;
   } row_t;

   logic                   fe_clk;
   logic                   rst_n_i;
   logic [7:0]             fe_data_i;
   logic                   fe_rxvalid_i;
   logic                   fe_rxactive_i;
   logic                   arm_i;
   pattern_t               pattern_i;
   pattern_t               mask_i;
   logic [DELAY_WIDTH-1:0] delay_i;
   logic [PULSE_WIDTH-1:0] width_i;
   logic                   trig_o;
   logic                   armed_o;

   row_t rows[$];
   int   cyc = 0;        // rising edges seen so far
   int   errors = 0;
   int   checks = 0;
   int   accept_cyc;     // edge that took the last byte of the window

   usb_trigger_top i_dut (
      .fe_clk        (fe_clk),
      .rst_n_i       (rst_n_i),
      .fe_data_i     (fe_data_i),
      .fe_rxvalid_i  (fe_rxvalid_i),
      .fe_rxactive_i (fe_rxactive_i),
      .arm_i         (arm_i),
      .pattern_i     (pattern_i),
      .mask_i        (mask_i),
      .delay_i       (delay_i),
      .width_i       (width_i),
      .trig_o        (trig_o),
      .armed_o       (armed_o)
   );

   always #50 fe_clk = ~fe_clk;

   always @(posedge fe_clk) cyc <= cyc + 1;

   ////////////////////////////////////////////////////////////////////////////
   // bus drivers
   ////////////////////////////////////////////////////////////////////////////

   task automatic apply_reset();
      @(posedge fe_clk);
      #1 rst_n_i = 1'b0;
      repeat (5) @(posedge fe_clk);
      #1 rst_n_i = 1'b1;
      checks++;
      if (armed_o !== 1'b0 || trig_o !== 1'b0) begin
         $display("mismatch after reset: armed_o 0x%h trig_o 0x%h, expected 0x0", armed_o,
                  trig_o);
         errors++;
      end
   endtask

   task automatic drive_byte(input logic [7:0] b);
      @(posedge fe_clk);
      #1;
      fe_data_i     = b;
      fe_rxvalid_i  = 1'b1;
      fe_rxactive_i = 1'b1;
   endtask

   task automatic drive_idle(input logic active);
      @(posedge fe_clk);
      #1;
      fe_data_i     = 8'h00;
      fe_rxvalid_i  = 1'b0;
      fe_rxactive_i = active;   // low ends the packet
   endtask

   task automatic strobe_arm();
      @(posedge fe_clk);
      #1 arm_i = 1'b1;
      @(posedge fe_clk);
      #1 arm_i = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // one table row
   ////////////////////////////////////////////////////////////////////////////

   task automatic run_row(input row_t r, input int idx);
      logic [63:0] data;
      int          first;    // packet byte under window byte 0
      int          waited;
      int          len;
      bit          seen;
      data  = r.data;
      first = r.len - PATTERN_BYTES;
      if (r.rand_fill) begin
         for (int j = 0; j < PATTERN_BYTES; j++) begin
            if (r.mask[j] == 8'h00 && first + j >= 0) begin
               data[(first + j) * 8 +: 8] = 8'($urandom);
            end
         end
      end
      if (!r.keep) begin
         apply_reset();
      end
      pattern_i = r.pattern;
      mask_i    = r.mask;
      delay_i   = r.delay;
      width_i   = r.width;
      if (r.arm) begin
         strobe_arm();
      end
      checks++;
      if (armed_o !== r.arm) begin
         $display("mismatch row %0d armed_o: expected 0x%h, actual 0x%h", idx, r.arm, armed_o);
         errors++;
      end
      for (int i = 0; i < r.len; i++) begin
         if (i > 0 && i == r.split) begin
            drive_idle(1'b0);
         end else if (i > 0 && r.gap) begin
            drive_idle(1'b1);
         end
         drive_byte(data[i * 8 +: 8]);
      end
      accept_cyc = cyc + 1;
      drive_idle(1'b0);
      if (r.arm_late) begin
         strobe_arm();   // lands in DELAY
      end
      seen   = 1'b0;
      waited = 0;
      while (!seen && waited < int'(r.delay) + 3 + SLACK) begin
         @(negedge fe_clk);
         waited++;
         seen = trig_o;
      end
      checks++;
      if (r.expect_trig && !seen) begin
         $display("timeout in row %0d: trig_o never rose after the matching packet", idx);
         errors++;
      end else if (!r.expect_trig && seen) begin
         $display("row %0d: trig_o rose although no trigger was expected", idx);
         errors++;
      end else if (seen) begin
         if (cyc - accept_cyc != int'(r.delay) + 3) begin
            $display("mismatch row %0d trig_o latency: expected 0x%h, actual 0x%h", idx,
                     int'(r.delay) + 3, cyc - accept_cyc);
            errors++;
         end
         if (armed_o !== 1'b0) begin
            $display("mismatch row %0d armed_o in pulse: expected 0x0, actual 0x%h", idx,
                     armed_o);
            errors++;
         end
         len = 0;
         while (trig_o && len <= int'(r.width) + SLACK) begin
            len++;
            @(negedge fe_clk);
         end
         if (trig_o) begin
            $display("timeout in row %0d: trig_o did not fall again", idx);
            errors++;
         end else if (len != int'(r.width)) begin
            $display("mismatch row %0d trig_o width: expected 0x%h, actual 0x%h", idx,
                     r.width, len);
            errors++;
         end
         // back in idle, no second pulse
         for (int k = 0; k < SLACK; k++) begin
            @(negedge fe_clk);
            if (trig_o || armed_o) begin
               $display("row %0d: trig_o or armed_o high after the pulse ended", idx);
               errors++;
               break;
            end
         end
      end
   endtask

   initial begin
      fe_clk        = 1'b0;
      rst_n_i       = 1'b0;
      fe_data_i     = 8'h00;
      fe_rxvalid_i  = 1'b0;
      fe_rxactive_i = 1'b0;
      arm_i         = 1'b0;
      pattern_i     = '0;
      mask_i        = '0;
      delay_i       = '0;
      width_i       = 1;
      void'($urandom(32'h16da));

      // data, len, gap, split, arm, keep, arm_late, rand_fill,
      // pattern, mask, delay, width, expect_trig
      rows.push_back('{64'h0000_0000_A5C3_1E2D, 4, 0, 0, 1, 0, 0, 0,
                       32'hA5C3_1E2D, 32'hFFFF_FFFF, 0, 1, 1});
      rows.push_back('{64'h00A5_C31E_2D11_2233, 7, 0, 0, 1, 0, 0, 0,
                       32'hA5C3_1E2D, 32'hFFFF_FFFF, 6, 4, 1});
      rows.push_back('{64'h0000_0000_8100_4200, 4, 0, 0, 1, 0, 0, 1,
                       32'h8100_4200, 32'hFF00_FF00, 3, 2, 1});
      rows.push_back('{64'h0000_0000_5C3A_00EE, 5, 0, 0, 1, 0, 0, 1,
                       32'h0055_AA00, 32'h00F0_0F00, 1, 5, 1});
      rows.push_back('{64'h0000_0000_CAFE_0B0F, 4, 0, 0, 1, 0, 0, 0,
                       32'hCAFE_0B0E, 32'hFFFF_FF01, 0, 1, 0});
      rows.push_back('{64'h0000_0013_579B_DF42, 5, 1, 0, 1, 0, 0, 0,
                       32'h1357_9BDF, 32'hFFFF_FFFF, 2, 3, 1});
      rows.push_back('{64'h0000_1357_9BDF_4242, 6, 0, 3, 1, 0, 0, 0,
                       32'h1357_9BDF, 32'hFFFF_FFFF, 0, 1, 0});
      // three bytes sit in window bytes 3..1, so only the byte count blocks a match
      rows.push_back('{64'h0000_0000_0057_9BDF, 3, 0, 0, 1, 0, 0, 0,
                       32'h579B_DF00, 32'hFFFF_FF00, 0, 1, 0});
      rows.push_back('{64'h0000_0000_A5C3_1E2D, 4, 0, 0, 0, 0, 0, 0,
                       32'hA5C3_1E2D, 32'hFFFF_FFFF, 0, 1, 0});
      rows.push_back('{64'h0000_0000_A5C3_1E2D, 4, 0, 0, 1, 0, 1, 0,
                       32'hA5C3_1E2D, 32'hFFFF_FFFF, 10, 2, 1});
      rows.push_back('{64'h0000_0000_A5C3_1E2D, 4, 0, 0, 0, 1, 0, 0,
                       32'hA5C3_1E2D, 32'hFFFF_FFFF, 0, 1, 0});

      apply_reset();
      foreach (rows[k]) begin
         run_row(rows[k], k);
      end

      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: verification/usb_trigger_sva.sv
`timescale 1ns/100ps

module usb_trigger_sva
   import pw_trig_pkg::*;
(
   input logic        fe_clk,
   input logic        rst_n_i,
   input logic        trig_i,
   input logic        armed_i,
   input trig_state_e state_i
);

   logic armed_seen;   // armed since the last pulse

   always_ff @(posedge fe_clk) begin
      if (!rst_n_i) begin
         armed_seen <= 1'b0;
      end else if (armed_i) begin
         armed_seen <= 1'b1;
      end else if (trig_i) begin
         armed_seen <= 1'b0;
      end
   end

   trig_armed_excl: assert property (@(posedge fe_clk) disable iff (!rst_n_i)
      !(trig_i && armed_i))
      else $error("trig_o and armed_o high together");

   reset_outputs_low: assert property (@(posedge fe_clk)
      !rst_n_i |=> (!trig_i && !armed_i))
      else $error("trig_o or armed_o high after a reset cycle");

   // a pulse needs an arm before it
   trig_after_arm: assert property (@(posedge fe_clk) disable iff (!rst_n_i)
      $rose(trig_i) |-> armed_seen)
      else $error("trig_o rose without armed_o before it");

   // state only steps idle, armed, delay, pulse and back to idle
   state_legal: assert property (@(posedge fe_clk) disable iff (!rst_n_i)
      state_i != $past(state_i) |->
         ($past(state_i) == ST_IDLE  && state_i == ST_ARMED) ||
         ($past(state_i) == ST_ARMED && state_i == ST_DELAY) ||
         ($past(state_i) == ST_DELAY && state_i == ST_PULSE) ||
         ($past(state_i) == ST_PULSE && state_i == ST_IDLE))
      else $error("sequencer state took an illegal step");

endmodule

bind usb_trigger_top usb_trigger_sva i_sva (
   .fe_clk  (fe_clk),
   .rst_n_i (rst_n_i),
   .trig_i  (trig_o),
   .armed_i (armed_o),
   .state_i (i_sequencer.state_q)
);
